/* src/sha256_pkg.sv */
`default_nettype none

package sha256_pkg;

  localparam int word_w = 32;
  localparam int block_w = 512;
  localparam int digest_w = 256;
  localparam int digest_words = digest_w / word_w;
  localparam int num_rounds = 64;
  localparam int sched_depth = 16;

  typedef logic [word_w-1:0] word_t;
  typedef logic [block_w-1:0] block_t;

  // Word 0 sits in the top 32 bits of the flat view
  typedef union packed {
    logic [digest_w-1:0] flat;
    word_t [0:digest_words-1] words;
  } digest_u;

  // FIPS 180-4 initial hash value H(0), words H0 to H7
  localparam logic [digest_w-1:0] hash_init =
    256'h6a09e667bb67ae853c6ef372a54ff53a510e527f9b05688c1f83d9ab5be0cd19;

  localparam word_t round_k [0:num_rounds-1] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Rotate right by n bits
  function automatic word_t rotr(word_t x, int unsigned n);
    return (x >> n) | (x << (word_w - n));
  endfunction

  function automatic word_t ch(word_t x, word_t y, word_t z);
    return (x & y) ^ (~x & z);
  endfunction

  function automatic word_t maj(word_t x, word_t y, word_t z);
    return (x & y) ^ (x & z) ^ (y & z);
  endfunction

  function automatic word_t big_sigma0(word_t x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic word_t big_sigma1(word_t x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  // The last term of the schedule mixing is a plain shift
  function automatic word_t small_sigma0(word_t x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic word_t small_sigma1(word_t x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

endpackage

`default_nettype wire

/* src/spi_block_receiver.sv */
`default_nettype none

module spi_block_receiver (
  input  logic               clk,
  input  logic               block_load,
  input  logic               sck,
  input  logic               sdi,
  output sha256_pkg::block_t block,
  output logic               block_valid
);

  logic       sck_s1;
  logic       sck_s2;
  logic       sck_d;
  logic       sdi_s1;
  logic       sdi_s2;
  logic       sck_rise;
  logic       block_full;
  // Counts received bits up to 512
  logic [9:0] bit_count;

  assign sck_rise   = sck_s2 & ~sck_d;
  assign block_full = (bit_count == 10'(sha256_pkg::block_w));

  // sdi goes through the same two stages so it lines up with sck_s2
  always_ff @(posedge clk or negedge block_load) begin
    if (!block_load) begin
      sck_s1      <= 1'b0;
      sck_s2      <= 1'b0;
      sck_d       <= 1'b0;
      sdi_s1      <= 1'b0;
      sdi_s2      <= 1'b0;
      bit_count   <= '0;
      block_valid <= 1'b0;
    end else begin
      sck_s1      <= sck;
      sck_s2      <= sck_s1;
      sck_d       <= sck_s2;
      sdi_s1      <= sdi;
      sdi_s2      <= sdi_s1;
      block_valid <= 1'b0;
      if (sck_rise && !block_full) begin
        bit_count   <= bit_count + 10'd1;
        block_valid <= (bit_count == 10'(sha256_pkg::block_w - 1));
      end
    end
  end

  // The first bit sent ends up in block[511]
  always_ff @(posedge clk) begin
    if (sck_rise && !block_full) begin
      block <= {block[sha256_pkg::block_w-2:0], sdi_s2};
    end
  end

  valid_single: assert property (@(posedge clk) disable iff (!block_load)
    block_valid |=> !block_valid);

  count_bound: assert property (@(posedge clk) disable iff (!block_load)
    bit_count <= 10'(sha256_pkg::block_w));

endmodule

`default_nettype wire

/* src/sha256_message_schedule.sv */
`default_nettype none

module sha256_message_schedule (
  input  logic               clk,
  input  logic               block_load,
  input  sha256_pkg::block_t block,
  input  logic               sched_load,
  input  logic               sched_advance,
  output sha256_pkg::word_t  sched_word
);

  // window[0] is W(t), window[15] is W(t+15)
  sha256_pkg::word_t window [0:sha256_pkg::sched_depth-1];
  sha256_pkg::word_t next_word;

  // W(t+16) from W(t+14), W(t+9), W(t+1) and W(t)
  assign next_word = sha256_pkg::small_sigma1(window[sha256_pkg::sched_depth-2])
                   + window[sha256_pkg::sched_depth-7]
                   + sha256_pkg::small_sigma0(window[1])
                   + window[0];

  assign sched_word = window[0];

  always_ff @(posedge clk) begin
    if (sched_load) begin
      // Message word 0 is the top word of the block
      for (int i = 0; i < sha256_pkg::sched_depth; i++) begin
        window[i] <= block[sha256_pkg::block_w-1-i*sha256_pkg::word_w -: sha256_pkg::word_w];
      end
    end else if (sched_advance) begin
      for (int i = 0; i < sha256_pkg::sched_depth - 1; i++) begin
        window[i] <= window[i+1];
      end
      window[sha256_pkg::sched_depth-1] <= next_word;
    end
  end

  // Each load is followed by exactly one run of rounds
  round_run: assert property (@(posedge clk) disable iff (!block_load)
    sched_load |=> sched_advance [*sha256_pkg::num_rounds] ##1 !sched_advance);

endmodule

`default_nettype wire

/* src/sha256_compress.sv */
`default_nettype none

module sha256_compress (
  input  logic                clk,
  input  logic                block_load,
  input  logic                block_valid,
  input  sha256_pkg::word_t   sched_word,
  output logic                sched_load,
  output logic                sched_advance,
  output sha256_pkg::digest_u digest,
  output logic                digest_valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_round,
    st_finish
  } state_t;

  localparam sha256_pkg::digest_u init = sha256_pkg::hash_init;

  state_t              state;
  logic [5:0]          round;
  sha256_pkg::word_t   a;
  sha256_pkg::word_t   b;
  sha256_pkg::word_t   c;
  sha256_pkg::word_t   d;
  sha256_pkg::word_t   e;
  sha256_pkg::word_t   f;
  sha256_pkg::word_t   g;
  sha256_pkg::word_t   h;
  sha256_pkg::word_t   k;
  sha256_pkg::word_t   t1;
  sha256_pkg::word_t   t2;

  assign k = sha256_pkg::round_k[round];

  assign t1 = h + sha256_pkg::big_sigma1(e) + sha256_pkg::ch(e, f, g) + k + sched_word;
  assign t2 = sha256_pkg::big_sigma0(a) + sha256_pkg::maj(a, b, c);

  assign sched_load    = (state == st_load);
  assign sched_advance = (state == st_round);
  assign digest_valid  = (state == st_finish);

  always_ff @(posedge clk or negedge block_load) begin
    if (!block_load) begin
      state <= st_idle;
      round <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (block_valid) begin
            state <= st_load;
          end
        end
        st_load: begin
          state <= st_round;
          round <= '0;
        end
        st_round: begin
          round <= round + 6'd1;
          if (round == 6'(sha256_pkg::num_rounds - 1)) begin
            state <= st_finish;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Working variables load H(0) alongside the schedule window
  always_ff @(posedge clk) begin
    if (state == st_load) begin
      {a, b, c, d, e, f, g, h} <= init.flat;
    end else if (state == st_round) begin
      h <= g;
      g <= f;
      f <= e;
      e <= d + t1;
      d <= c;
      c <= b;
      b <= a;
      a <= t1 + t2;
    end
  end

  // Final addition is valid in the finish cycle and held afterwards
  always_comb begin
    digest.words[0] = a + init.words[0];
    digest.words[1] = b + init.words[1];
    digest.words[2] = c + init.words[2];
    digest.words[3] = d + init.words[3];
    digest.words[4] = e + init.words[4];
    digest.words[5] = f + init.words[5];
    digest.words[6] = g + init.words[6];
    digest.words[7] = h + init.words[7];
  end

  // The receiver delivers one block per reset, never mid-hash
  no_overlap: assert property (@(posedge clk) disable iff (!block_load)
    (state == st_round) |-> !block_valid);

endmodule

`default_nettype wire

/* src/spi_digest_transmitter.sv */
`default_nettype none

module spi_digest_transmitter (
  input  logic                clk,
  input  logic                block_load,
  input  logic                sck,
  input  sha256_pkg::digest_u digest,
  input  logic                digest_valid,
  output logic                sdo,
  output logic                done
);

  logic                            sck_s1;
  logic                            sck_s2;
  logic                            sck_d;
  logic                            sck_fall;
  // Bits still to come after the one on sdo
  logic [sha256_pkg::digest_w-2:0] shift_reg;

  assign sck_fall = ~sck_s2 & sck_d;

  always_ff @(posedge clk or negedge block_load) begin
    if (!block_load) begin
      sck_s1 <= 1'b0;
      sck_s2 <= 1'b0;
      sck_d  <= 1'b0;
      sdo    <= 1'b0;
      done   <= 1'b0;
    end else begin
      sck_s1 <= sck;
      sck_s2 <= sck_s1;
      sck_d  <= sck_s2;
      if (digest_valid) begin
        // Bit 255 is on sdo before the host's first rising sck
        sdo  <= digest.flat[sha256_pkg::digest_w-1];
        done <= 1'b1;
      end else if (sck_fall && done) begin
        sdo <= shift_reg[sha256_pkg::digest_w-2];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (digest_valid) begin
      shift_reg <= digest.flat[sha256_pkg::digest_w-2:0];
    end else if (sck_fall && done) begin
      shift_reg <= {shift_reg[sha256_pkg::digest_w-3:0], 1'b0};
    end
  end

  sdo_cause: assert property (@(posedge clk) disable iff (!block_load)
    $changed(sdo) |-> $past(digest_valid) || $past(sck_fall && done));

endmodule

`default_nettype wire

/* src/upcoin_top.sv */
`default_nettype none

module upcoin_top (
  input  logic clk,
  input  logic block_load,
  input  logic sck,
  input  logic sdi,
  output logic sdo,
  output logic done
);

  sha256_pkg::block_t  block;
  logic                block_valid;
  logic                sched_load;
  logic                sched_advance;
  sha256_pkg::word_t   sched_word;
  sha256_pkg::digest_u digest;
  logic                digest_valid;

  spi_block_receiver rx_i (
    .clk         (clk),
    .block_load  (block_load),
    .sck         (sck),
    .sdi         (sdi),
    .block       (block),
    .block_valid (block_valid)
  );

  sha256_message_schedule sched_i (
    .clk           (clk),
    .block_load    (block_load),
    .block         (block),
    .sched_load    (sched_load),
    .sched_advance (sched_advance),
    .sched_word    (sched_word)
  );

  sha256_compress compress_i (
    .clk           (clk),
    .block_load    (block_load),
    .block_valid   (block_valid),
    .sched_word    (sched_word),
    .sched_load    (sched_load),
    .sched_advance (sched_advance),
    .digest        (digest),
    .digest_valid  (digest_valid)
  );

  // Falling edges of the shared sck pin drive the readout
  spi_digest_transmitter tx_i (
    .clk          (clk),
    .block_load   (block_load),
    .sck          (sck),
    .digest       (digest),
    .digest_valid (digest_valid),
    .sdo          (sdo),
    .done         (done)
  );

endmodule

`default_nettype wire

/* verification/upcoin_tb.sv */
`default_nettype none

module upcoin_tb;

  localparam int num_tests  = 4;
  localparam int entry_words = 24;
  localparam int half_bit   = 8;
  localparam int done_limit = 200;
  // One run is a block, up to 3 junk bits and a readout at 16 clk per bit
  localparam int run_cycles = (512 + 3 + 256) * 2 * half_bit + 2 * 2000 + 66;

  logic        clk;
  logic        block_load;
  logic        sck;
  logic        sdi;
  logic        sdo;
  logic        done;
  logic [31:0] stim [0:num_tests*entry_words-1];
  integer      seed;
  int          error_count;
  int          pass_count;
  int          fail_count;

  upcoin_top dut_i (
    .clk        (clk),
    .block_load (block_load),
    .sck        (sck),
    .sdi        (sdi),
    .sdo        (sdo),
    .done       (done)
  );

  always #5 clk = ~clk;

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic compare(input string name, input logic [255:0] actual,
                         input logic [255:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got %0h, expected %0h", name, actual, expected);
      error_count++;
    end
  endtask

  task automatic apply_reset();
    block_load = 1'b0;
    sck        = 1'b0;
    sdi        = 1'b0;
    wait_clocks(8);
    block_load = 1'b1;
  endtask

  // sdi is set while sck is low and sampled on the rising edge
  task automatic send_bit(input logic value);
    sdi = value;
    wait_clocks(half_bit);
    sck = 1'b1;
    wait_clocks(half_bit);
    sck = 1'b0;
  endtask

  task automatic send_bits(input logic [511:0] data, input int count);
    for (int i = 0; i < count; i++) begin
      send_bit(data[511-i]);
      if (i < 511) begin
        compare("done", 256'(done), '0);
      end
    end
  endtask

  // Full block, optional junk bits, then readout of all 256 digest bits
  task automatic hash_vector(input int idx, input int extra);
    logic [767:0] entry;
    logic [255:0] received;
    int           waited;
    entry    = '0;
    received = '0;
    waited   = 0;
    for (int w = 0; w < entry_words; w++) begin
      entry = {entry[735:0], stim[idx*entry_words+w]};
    end
    send_bits(entry[767:256], 512);
    for (int i = 0; i < extra; i++) begin
      send_bit(1'($random(seed)));
    end
    while (!done && waited < done_limit) begin
      wait_clocks(1);
      waited++;
    end
    if (!done) begin
      $display("Error: done did not rise within %0d clk cycles of the last bit", done_limit);
      error_count++;
    end else begin
      compare("sdo", 256'(sdo), 256'(entry[255]));
      for (int i = 0; i < 256; i++) begin
        wait_clocks(half_bit);
        received = {received[254:0], sdo};
        sck = 1'b1;
        wait_clocks(half_bit);
        sck = 1'b0;
      end
      compare("digest", received, entry[255:0]);
      wait_clocks(half_bit);
      compare("done", 256'(done), 256'(1'b1));
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("Test %s: pass", name);
      pass_count++;
    end else begin
      $display("Test %s: fail", name);
      fail_count++;
    end
  endtask

  initial begin
    repeat ((num_tests + 2) * run_cycles) @(posedge clk);
    $display("Timeout: the tests did not finish within the expected number of clk cycles");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    sha256_pkg::block_t junk;
    int                 errors_before;
    int                 extra;
    clk         = 1'b0;
    block_load  = 1'b0;
    sck         = 1'b0;
    sdi         = 1'b0;
    seed        = 32'hfe282a2c;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    $readmemh("verification/sha256_stimulus.hex", stim);
    for (int i = 0; i < num_tests; i++) begin
      errors_before = error_count;
      // Odd tests clock junk bits in while the block is being hashed
      extra = (i % 2 == 1) ? 1 + ({$random(seed)} % 3) : 0;
      apply_reset();
      wait_clocks({$random(seed)} % 16);
      compare("done", 256'(done), '0);
      hash_vector(i, extra);
      report_test($sformatf("vector %0d with %0d extra bits", i, extra), errors_before);
    end
    // Partial block cut off by reset, then a full block
    errors_before = error_count;
    for (int w = 0; w < 16; w++) begin
      junk[w*32 +: 32] = $random(seed);
    end
    apply_reset();
    send_bits(junk, 64 + ({$random(seed)} % 384));
    apply_reset();
    hash_vector(0, 0);
    report_test("reset during transfer", errors_before);
    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/sha256_stimulus.hex */
// Per line: 16 words of a padded 512-bit block, then the 8 words of its SHA-256 digest
// Messages in order: "abc", the empty message, "a", the quick brown fox sentence
61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018 ba7816bf 8f01cfea 414140de 5dae2223 b00361a3 96177a9c b410ff61 f20015ad
80000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 e3b0c442 98fc1c14 9afbf4c8 996fb924 27ae41e4 649b934c a495991b 7852b855
61800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000008 ca978112 ca1bbdca fac231b3 9a23dc4d a786eff8 147c4e72 b9807785 afee48bb
54686520 71756963 6b206272 6f776e20 666f7820 6a756d70 73206f76 65722074 6865206c 617a7920 646f6780 00000000 00000000 00000000 00000000 00000158 d7a8fbb3 07d78094 69ca9abc b0082e4f 8d5651e4 6d3cdb76 2d02d0bf 37c9e592

/* flist.f */
src/sha256_pkg.sv
src/spi_block_receiver.sv
src/sha256_message_schedule.sv
src/sha256_compress.sv
src/spi_digest_transmitter.sv
src/upcoin_top.sv
verification/upcoin_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= upcoin_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "Simulation failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
